// File: video_pkg.sv
// bus widths, register offsets, beam timing constants and the control word union
`default_nettype none

package video_pkg;

	// AXI4-Lite slave side
	localparam int axi_addr_w = 9;	// byte offsets up to 0x1ff
	localparam int axi_data_w = 32;	// only bits 15:0 carry data
	localparam logic [1:0] resp_okay = 2'b00;

	// chip register offsets (byte addresses)
	localparam logic [axi_addr_w-1:0] reg_vposr    = 9'h004;	// long_frame, ids, vpos msbs
	localparam logic [axi_addr_w-1:0] reg_vhposr   = 9'h006;	// vpos lsbs, hpos
	localparam logic [axi_addr_w-1:0] reg_bplcon0  = 9'h100;	// lace, ersy
	localparam logic [axi_addr_w-1:0] reg_beamcon0 = 9'h1dc;	// pal

	// horizontal timing in bus clocks, a line is h_total+1 counts
	localparam logic [8:0] h_total  = 9'd453;	// 227 colour clocks
	localparam logic [8:0] h_bstrt  = 9'd25;	// horizontal blanking start
	localparam logic [8:0] h_sstrt  = 9'd37;	// front porch end, hsync falls
	localparam logic [8:0] h_sstop  = 9'd70;	// hsync rises again
	localparam logic [8:0] h_bstop  = 9'd102;	// blanking ends, shortened for overscan
	localparam logic [8:0] h_center = 9'd264;	// half line point for interlace vsync

	// serration window opens one hsync width ahead of the hsync edge
	localparam logic [8:0] h_serr = h_sstrt - (h_sstop - h_sstrt);

	// vertical timing in lines
	localparam logic [10:0] v_sstrt = 11'd3;	// vsync start line
	localparam logic [10:0] v_sstop = 11'd5;	// 2.5 lines of vsync

	// total lines less one
	localparam logic [10:0] v_total_pal  = 11'd311;
	localparam logic [10:0] v_total_ntsc = 11'd261;

	// last line of vertical blanking, sprites get fetched here
	localparam logic [10:0] v_bstop_pal  = 11'd25;	// first visible line 0x1a
	localparam logic [10:0] v_bstop_ntsc = 11'd20;	// first visible line 0x15

	// BPLCON0 fields used by the beam logic
	typedef struct packed
	{
		logic [12:0] other;	// bitplane control, not used here
		logic        lace;	// interlace enable
		logic        ersy;	// external resync, freezes the position latch
		logic        unused;
	} bplcon0_t;

	// BEAMCON0 fields used by the beam logic
	typedef struct packed
	{
		logic [9:0] other;	// ecs beam features, not implemented
		logic       pal;	// 1 pal line total, 0 ntsc
		logic [4:0] low;
	} beamcon0_t;

	// one write word seen as either register
	typedef union packed
	{
		bplcon0_t  bplcon0;
		beamcon0_t beamcon0;
	} ctrl_word_u;

endpackage

`default_nettype wire

// File: beam_regs.sv
// beam_regs: AXI4-Lite slave with mode bits, beam position latch and read mux
`timescale 1ns/100ps
`default_nettype none

module beam_regs
(
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire                                 ntsc,	// board strap, sets pal at reset
	input  wire                                 ecsena,	// ecs chip id strap
	input  wire  [video_pkg::axi_addr_w-1:0]    awaddr,
	input  wire                                 awvalid,
	output logic                                awready,
	input  wire  [video_pkg::axi_data_w-1:0]    wdata,
	input  wire  [video_pkg::axi_data_w/8-1:0]  wstrb,
	input  wire                                 wvalid,
	output logic                                wready,
	output logic [1:0]                          bresp,
	output logic                                bvalid,
	input  wire                                 bready,
	input  wire  [video_pkg::axi_addr_w-1:0]    araddr,
	input  wire                                 arvalid,
	output logic                                arready,
	output logic [video_pkg::axi_data_w-1:0]    rdata,
	output logic [1:0]                          rresp,
	output logic                                rvalid,
	input  wire                                 rready,
	input  wire  [8:0]                          hpos,	// live beam position
	input  wire  [10:0]                         vpos,
	input  wire                                 long_frame,
	input  wire                                 long_line,
	output logic                                lace,	// mode bits to the datapath
	output logic                                ersy,
	output logic                                pal
);

	video_pkg::ctrl_word_u wr_word;	// write data, view picked by address
	logic        wr_accept;	// aw and w taken together
	logic        wr_full;	// low halfword fully strobed
	logic        rd_accept;
	logic [10:0] vposr;	// latched beam position
	logic [8:1]  hposr;	// hpos in colour clocks
	logic [15:0] rd_mux;

	// write channel, address and data must arrive together
	assign wr_accept = awvalid & wvalid & ~bvalid;
	assign awready = wr_accept;
	assign wready = wr_accept;
	assign wr_full = wr_accept & (wstrb[1:0] == 2'b11);	// partial writes dropped
	assign wr_word = wdata[15:0];
	assign bresp = video_pkg::resp_okay;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			lace <= 1'b0;
			ersy <= 1'b0;
			pal <= ~ntsc;	// follow the board strap until software writes
		end
		else if (wr_full)
		begin
			if (awaddr == video_pkg::reg_bplcon0)
			begin
				lace <= wr_word.bplcon0.lace;
				ersy <= wr_word.bplcon0.ersy;
			end
			if (awaddr == video_pkg::reg_beamcon0)
				pal <= wr_word.beamcon0.pal;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			bvalid <= 1'b0;
		else if (wr_accept)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;	// response taken
	end

	// position latch, ersy holds the last value as a genlock would
	always_ff @(posedge clk)
	begin
		if (hpos[0] && !ersy)	// odd counts only, one update per colour clock
		begin
			vposr <= vpos;
			hposr <= hpos[8:1];
		end
	end

	// read channel
	assign rd_accept = arvalid & ~rvalid;
	assign arready = rd_accept;
	assign rresp = video_pkg::resp_okay;

	always_comb
	begin
		case (araddr)
			video_pkg::reg_vposr:
				rd_mux = {long_frame, 1'b0, ecsena, ntsc, 4'b0000,
					long_line, 4'b0000, vposr[10:8]};
			video_pkg::reg_vhposr:
				rd_mux = {vposr[7:0], hposr[8:1]};
			default:
				rd_mux = 16'h0000;	// everything else reads as zero
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			rvalid <= 1'b0;
		else if (rd_accept)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (rd_accept)
			rdata <= {{(video_pkg::axi_data_w-16){1'b0}}, rd_mux};	// held until rready
	end

	// responses must not be withdrawn before the master takes them
	a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid);
	a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

// File: beam_position.sv
// beam_position: horizontal and vertical beam counters, interlace frames, eol and eof
`timescale 1ns/100ps
`default_nettype none

module beam_position
(
	input  wire         clk,
	input  wire         reset,
	input  wire         pal,	// selects the line total
	input  wire         lace,	// interlace, frames alternate long and short
	output logic [8:0]  hpos,	// horizontal count at bus clock
	output logic [10:0] vpos,	// line number
	output logic        long_frame,	// 1 in a frame with the extra line
	output logic        long_line,	// ntsc line toggle, length unchanged
	output logic        eol,	// start of line strobe
	output logic        eof	// start of frame strobe
);

	logic [10:0] vtotal;	// lines per frame less one
	logic        end_of_line;
	logic        vpos_enable;	// vertical step point
	logic        vpos_equ_vtotal;
	logic        extra_line;	// currently on the added line of a long frame
	logic        last_line;
	logic        end_of_frame;

	assign vtotal = pal ? video_pkg::v_total_pal : video_pkg::v_total_ntsc;

	// horizontal counter, 454 counts per line
	assign end_of_line = (hpos == video_pkg::h_total);

	always_ff @(posedge clk)
	begin
		if (reset || end_of_line)
			hpos <= 9'd0;
		else
			hpos <= hpos + 9'd1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			long_line <= 1'b0;
		else if (end_of_line)
			long_line <= pal ? 1'b0 : ~long_line;	// pal lines are all short
	end

	// vertical counter steps just after the line wrap
	assign vpos_enable = (hpos == 9'd3);
	assign vpos_equ_vtotal = (vpos == vtotal);

	// a long frame runs one line past vtotal
	assign last_line = long_frame ? extra_line : vpos_equ_vtotal;
	assign end_of_frame = vpos_enable && last_line;

	always_ff @(posedge clk)
	begin
		if (reset || end_of_frame)
			vpos <= 11'd0;
		else if (vpos_enable)
			vpos <= vpos + 11'd1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			extra_line <= 1'b0;
		else if (vpos_enable)
			extra_line <= long_frame && vpos_equ_vtotal;	// next line is the extra one
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			long_frame <= 1'b0;	// the first frame is short
		else if (end_of_frame)
			long_frame <= lace ? ~long_frame : 1'b1;
	end

	// strobes lead the vertical step by one count
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			eol <= 1'b0;
			eof <= 1'b0;
		end
		else
		begin
			eol <= (hpos == 9'd2);
			eof <= (hpos == 9'd2) && last_line;
		end
	end

	a_hpos_range: assert property (@(posedge clk) disable iff (reset)
		hpos <= video_pkg::h_total);

endmodule

`default_nettype wire

// File: sync_gen.sv
// sync_gen: horizontal, vertical and composite sync with serration pulses
`timescale 1ns/100ps
`default_nettype none

module sync_gen
(
	input  wire         clk,
	input  wire         reset,
	input  wire  [8:0]  hpos,
	input  wire  [10:0] vpos,
	input  wire         long_frame,	// shifts vsync by half a line
	output logic        hsync_n,
	output logic        vsync_n,
	output logic        csync_n
);

	logic vser;	// serration window ahead of each hsync
	logic at_hsstrt;
	logic at_center;

	assign at_hsstrt = (hpos == video_pkg::h_sstrt);
	assign at_center = (hpos == video_pkg::h_center);

	// 33 counts low, one count behind the compare
	always_ff @(posedge clk)
	begin
		if (reset)
			hsync_n <= 1'b1;
		else if (at_hsstrt)
			hsync_n <= 1'b0;
		else if (hpos == video_pkg::h_sstop)
			hsync_n <= 1'b1;
	end

	// short frame: sync start to line centre, long frame: centre to sync start
	always_ff @(posedge clk)
	begin
		if (reset)
			vsync_n <= 1'b1;
		else if (vpos == video_pkg::v_sstrt && (long_frame ? at_center : at_hsstrt))
			vsync_n <= 1'b0;
		else if (!long_frame && vpos == video_pkg::v_sstop && at_center)
			vsync_n <= 1'b1;
		else if (long_frame && vpos == (video_pkg::v_sstop + 11'd1) && at_hsstrt)
			vsync_n <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			vser <= 1'b0;
		else if (hpos == video_pkg::h_serr)
			vser <= 1'b1;
		else if (at_hsstrt)
			vser <= 1'b0;	// closes as hsync opens
	end

	// serration keeps the encoder locked during vsync
	assign csync_n = (hsync_n & vsync_n) | vser;

endmodule

`default_nettype wire

// File: blank_gen.sv
// blank_gen: vertical blanking, last blanked line flag and composite blanking
`timescale 1ns/100ps
`default_nettype none

module blank_gen
(
	input  wire         clk,
	input  wire         reset,
	input  wire         pal,
	input  wire  [8:0]  hpos,
	input  wire  [10:0] vpos,
	output logic        vbl,	// vertical blanking
	output logic        vblend,	// last blanked line
	output logic        blank	// composite display blanking
);

	logic [10:0] vbstop;

	assign vbstop = pal ? video_pkg::v_bstop_pal : video_pkg::v_bstop_ntsc;

	assign vbl = (vpos <= vbstop);	// from line 0 on
	assign vblend = (vpos == vbstop);

	// horizontal window, held through the whole line in vbl
	always_ff @(posedge clk)
	begin
		if (reset)
			blank <= 1'b1;
		else if (hpos == video_pkg::h_bstrt)
			blank <= 1'b1;
		else if (hpos == video_pkg::h_bstop)
			blank <= vbl;
	end

endmodule

`default_nettype wire

// File: beam_timing_top.sv
// beam_timing_top: control block and beam datapath blocks
`timescale 1ns/100ps
`default_nettype none

module beam_timing_top
(
	input  wire                                clk,
	input  wire                                reset,
	input  wire                                ntsc,
	input  wire                                ecsena,
	input  wire  [video_pkg::axi_addr_w-1:0]   awaddr,
	input  wire                                awvalid,
	output wire                                awready,
	input  wire  [video_pkg::axi_data_w-1:0]   wdata,
	input  wire  [video_pkg::axi_data_w/8-1:0] wstrb,
	input  wire                                wvalid,
	output wire                                wready,
	output wire  [1:0]                         bresp,
	output wire                                bvalid,
	input  wire                                bready,
	input  wire  [video_pkg::axi_addr_w-1:0]   araddr,
	input  wire                                arvalid,
	output wire                                arready,
	output wire  [video_pkg::axi_data_w-1:0]   rdata,
	output wire  [1:0]                         rresp,
	output wire                                rvalid,
	input  wire                                rready,
	output wire  [8:0]                         hpos,
	output wire  [10:0]                        vpos,
	output wire                                hsync_n,
	output wire                                vsync_n,
	output wire                                csync_n,
	output wire                                blank,
	output wire                                vbl,
	output wire                                vblend,
	output wire                                eol,
	output wire                                eof
);

	wire lace;	// mode bits from the register block
	wire ersy;
	wire pal;
	wire long_frame;	// frame state back to the register block
	wire long_line;

	beam_regs u_regs (.clk(clk), .reset(reset), .ntsc(ntsc), .ecsena(ecsena),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.hpos(hpos), .vpos(vpos), .long_frame(long_frame), .long_line(long_line),
		.lace(lace), .ersy(ersy), .pal(pal));

	beam_position u_position (.clk(clk), .reset(reset), .pal(pal), .lace(lace),
		.hpos(hpos), .vpos(vpos), .long_frame(long_frame), .long_line(long_line),
		.eol(eol), .eof(eof));

	sync_gen u_sync (.clk(clk), .reset(reset), .hpos(hpos), .vpos(vpos),
		.long_frame(long_frame), .hsync_n(hsync_n), .vsync_n(vsync_n),
		.csync_n(csync_n));

	blank_gen u_blank (.clk(clk), .reset(reset), .pal(pal), .hpos(hpos),
		.vpos(vpos), .vbl(vbl), .vblend(vblend), .blank(blank));

endmodule

`default_nettype wire

// File: tb_beam_timing.sv
// testbench with register table, horizontal, vertical and frame timing, blanking and position latch checks
`timescale 1ns/100ps
`default_nettype none

module tb_beam_timing;

	localparam int line_cycles = 454;	// hpos 0..453
	localparam int frame_cycles = line_cycles * 313;	// longest pal frame
	localparam int watchdog_cycles = 5 * frame_cycles + 20000;	// frames used plus margin
	localparam int handshake_limit = 64;
	localparam int n_rows = 10;

	logic        clk;
	logic        reset;
	logic        ntsc;
	logic        ecsena;
	logic [8:0]  awaddr;
	logic        awvalid;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        bready;
	logic [8:0]  araddr;
	logic        arvalid;
	logic        rready;
	wire         awready, wready, bvalid, arready, rvalid;
	wire  [1:0]  bresp, rresp;
	wire  [31:0] rdata;
	wire  [8:0]  hpos;
	wire  [10:0] vpos;
	wire         hsync_n, vsync_n, csync_n;
	wire         blank, vbl, vblend, eol, eof;

	int          cycle_count;	// posedges since time 0
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          test_start_errors;
	logic [15:0] lfsr;	// gap generator state
	logic [10:0] vpos_at_read;	// vpos port when the read data arrived

	// register table with one AXI operation per row
	logic        row_wr   [n_rows];
	logic [8:0]  row_addr [n_rows];
	logic [31:0] row_data [n_rows];
	logic [3:0]  row_strb [n_rows];
	logic [31:0] row_exp  [n_rows];
	logic [31:0] row_mask [n_rows];
	int          row_count;

	beam_timing_top UUT (.clk(clk), .reset(reset), .ntsc(ntsc), .ecsena(ecsena),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.hpos(hpos), .vpos(vpos), .hsync_n(hsync_n), .vsync_n(vsync_n), .csync_n(csync_n),
		.blank(blank), .vbl(vbl), .vblend(vblend), .eol(eol), .eof(eof));

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 50 MHz bus clock
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	initial
	begin
		#(watchdog_cycles * 20);
		$display("timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
		$display(">>> FAIL");
		$finish;
	end

	// galois form with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic random_gap;	// 0 to 3 idle cycles from two lfsr bits
		logic [1:0] n;
		begin
			n = 2'd0;
			repeat (2)
			begin
				n = {n[0], lfsr[0]};
				lfsr = lfsr_next(lfsr);
			end
			repeat (n) @(posedge clk);
		end
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic add_row(input logic wr, input logic [8:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [31:0] exp, input logic [31:0] mask);
		row_wr[row_count] = wr;
		row_addr[row_count] = addr;
		row_data[row_count] = data;
		row_strb[row_count] = strb;
		row_exp[row_count] = exp;
		row_mask[row_count] = mask;
		row_count++;
	endtask

	task automatic begin_test;
		test_start_errors = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start_errors)
			$display("test %s: passed", name);
		else
		begin
			$display("test %s: failed with %0d errors", name, errors - test_start_errors);
			tests_failed++;
		end
	endtask

	// picks the watched dut output by name
	function automatic logic watched_level(input string what);
		case (what)
			"hsync_n": watched_level = hsync_n;
			"vsync_n": watched_level = vsync_n;
			"csync_n": watched_level = csync_n;
			"eof":     watched_level = eof;
			default:   watched_level = 1'bx;	// unknown name never matches
		endcase
	endfunction

	// samples at the falling edge where every DUT output is settled
	task automatic wait_cond(input string what, input logic level, output int stamp);
		int n;
		begin
			n = 0;
			@(negedge clk);
			while (watched_level(what) !== level && n < 2 * frame_cycles)
			begin
				@(negedge clk);
				n++;
			end
			if (n >= 2 * frame_cycles)
			begin
				$display("error: %s never reached %b", what, level);
				errors++;
			end
			stamp = cycle_count;
		end
	endtask

	task automatic axi_write(input logic [8:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		int n;
		begin
			n = 0;
			@(posedge clk);
			awaddr <= addr;
			awvalid <= 1'b1;
			wdata <= data;
			wstrb <= strb;
			wvalid <= 1'b1;
			@(negedge clk);
			while (!(awready && wready) && n < handshake_limit)
			begin
				@(negedge clk);
				n++;
			end
			@(posedge clk);	// accepted on this edge
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			resp = 2'b11;
			if (n >= handshake_limit)
			begin
				$display("error: write to %h was not accepted", addr);
				errors++;
			end
			else
			begin
				n = 0;
				@(negedge clk);
				while (!bvalid && n < handshake_limit)
				begin
					@(negedge clk);
					n++;
				end
				if (n >= handshake_limit)
				begin
					$display("error: write to %h got no response", addr);
					errors++;
				end
				resp = bresp;
				random_gap;
				@(posedge clk);
				bready <= 1'b1;
				@(posedge clk);
				bready <= 1'b0;
			end
		end
	endtask

	task automatic axi_read(input logic [8:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int n;
		begin
			n = 0;
			@(posedge clk);
			araddr <= addr;
			arvalid <= 1'b1;
			@(negedge clk);
			while (!arready && n < handshake_limit)
			begin
				@(negedge clk);
				n++;
			end
			@(posedge clk);
			arvalid <= 1'b0;
			n = 0;
			@(negedge clk);
			while (!rvalid && n < handshake_limit)
			begin
				@(negedge clk);
				n++;
			end
			if (n >= handshake_limit)
			begin
				$display("error: read from %h got no response", addr);
				errors++;
			end
			data = rdata;
			resp = rresp;
			vpos_at_read = vpos;
			random_gap;
			@(posedge clk);
			rready <= 1'b1;
			@(posedge clk);
			rready <= 1'b0;
		end
	endtask

	initial
	begin
		logic [31:0] d1, d2;
		logic [1:0]  resp;
		logic [7:0]  vp_now, vp_prev;
		int          s1, s2, s3, s4, s5;
		int          t;
		int          highs, rises;
		logic        prev;
		reset = 1'b1;
		ntsc = 1'b0;	// pal board
		ecsena = 1'b1;
		{awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
		{araddr, arvalid, rready} = '0;
		{cycle_count, errors, tests_run, tests_failed, row_count} = '0;
		lfsr = 16'd57350;

		add_row(0, 9'h004, 0, 0, 32'h0000_2000, 32'hffff_fff8);	// ecsena 1, ntsc 0
		add_row(0, 9'h000, 0, 0, 32'h0, 32'hffff_ffff);	// unknown offsets
		add_row(0, 9'h002, 0, 0, 32'h0, 32'hffff_ffff);
		add_row(0, 9'h1fe, 0, 0, 32'h0, 32'hffff_ffff);
		add_row(1, 9'h1dc, 32'h0000, 4'b0001, 0, 0);	// pal clear with a partial strobe
		add_row(1, 9'h100, 32'h0004, 4'b0010, 0, 0);	// lace set with a partial strobe
		add_row(0, 9'h004, 0, 0, 32'h0000_2000, 32'hffff_fff8);
		add_row(1, 9'h080, 32'hffff, 4'b1111, 0, 0);	// no register here
		add_row(0, 9'h080, 0, 0, 32'h0, 32'hffff_ffff);
		add_row(0, 9'h004, 0, 0, 32'h0000_2000, 32'hffff_fff8);

		repeat (8) @(posedge clk);
		reset <= 1'b0;

		begin_test;
		for (int i = 0; i < row_count; i++)
		begin
			random_gap;
			if (row_wr[i])
			begin
				axi_write(row_addr[i], row_data[i], row_strb[i], resp);
				check("bresp", resp, 2'b00);
			end
			else
			begin
				axi_read(row_addr[i], d1, resp);
				check("rresp", resp, 2'b00);
				check($sformatf("rdata at %h", row_addr[i]), d1 & row_mask[i], row_exp[i]);
			end
		end
		end_test("register access");

		// hsync period and width, eol width
		begin_test;
		wait_cond("hsync_n", 1'b1, s1);
		wait_cond("hsync_n", 1'b0, s1);	// falling edge
		check("hpos at hsync_n fall", hpos, 38);	// one count after 37
		wait_cond("hsync_n", 1'b1, s2);
		wait_cond("hsync_n", 1'b0, s3);
		check("hsync_n low cycles", s2 - s1, 33);
		check("hsync_n period", s3 - s1, line_cycles);
		highs = 0;
		rises = 0;
		prev = 1'b0;
		repeat (2 * line_cycles)
		begin
			@(negedge clk);
			highs += eol;
			rises += (eol && !prev);
			prev = eol;
			if (eol)
				check("hpos at eol", hpos, 3);	// one count after 2
		end
		check("eol pulses in two lines", rises, 2);
		check("eol high cycles in two lines", highs, 2);
		end_test("horizontal timing");

		// pal blanking ends after line 25
		begin_test;
		if (vpos > 11'd25)
		begin
			$display("error: blanking check started after line 25");
			errors++;
		end
		while (vpos <= 11'd30 && errors == test_start_errors)
		begin
			@(negedge clk);
			check("vbl", vbl, vpos <= 11'd25);
			check("vblend", vblend, vpos == 11'd25);
			if (vbl)
				check("blank", blank, 1'b1);
		end
		end_test("vertical blanking");

		begin_test;
		repeat (2)
		begin
			random_gap;
			axi_read(9'h006, d1, resp);
			vp_now = vpos_at_read[7:0];
			vp_prev = vp_now - 8'd1;	// latch may still hold the previous line
			check("VHPOSR vpos byte", d1[15:8], (d1[15:8] == vp_prev) ? vp_prev : vp_now);
		end
		axi_write(9'h100, 32'h0002, 4'b0011, resp);	// ersy on freezes the latch
		axi_read(9'h006, d1, resp);
		repeat (100) @(posedge clk);
		axi_read(9'h006, d2, resp);
		check("VHPOSR with ersy", d2, d1);
		axi_write(9'h100, 32'h0000, 4'b0011, resp);
		end_test("position latch");

		begin_test;
		wait_cond("eof", 1'b1, s1);	// end of the short first frame
		wait_cond("eof", 1'b1, s2);
		check("pal frame cycles", s2 - s1, 313 * line_cycles);
		end_test("pal frame length");

		// long frame, vsync runs from the line 3 centre to the line 6 hsync start
		begin_test;
		axi_write(9'h1dc, 32'h0000, 4'b0011, resp);	// ntsc line total
		wait_cond("vsync_n", 1'b0, t);
		check("vpos at vsync_n fall", vpos, 3);
		check("hpos at vsync_n fall", hpos, 265);	// one count after the centre
		check("csync_n in vsync", csync_n, 1'b0);
		wait_cond("csync_n", 1'b1, t);	// serration pulse
		check("vpos at serration", vpos, 4);
		wait_cond("csync_n", 1'b0, t);
		check("hpos at serration end", hpos, 38);	// closes with hsync
		wait_cond("vsync_n", 1'b1, t);
		check("vpos at vsync_n rise", vpos, 6);
		check("hpos at vsync_n rise", hpos, 38);
		end_test("vertical sync");

		begin_test;
		wait_cond("eof", 1'b1, s3);
		check("ntsc frame cycles", s3 - s2, 263 * line_cycles);
		end_test("ntsc frame length");

		// frame after eof3 is still long so toggling starts at eof4
		begin_test;
		axi_write(9'h100, 32'h0004, 4'b0011, resp);
		wait_cond("eof", 1'b1, s4);
		wait_cond("eof", 1'b1, s5);
		check("interlace long frame cycles", s4 - s3, 263 * line_cycles);
		check("interlace short frame cycles", s5 - s4, 262 * line_cycles);
		end_test("interlace frames");

		$display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
video_pkg.sv
beam_regs.sv
beam_position.sv
sync_gen.sv
blank_gen.sv
beam_timing_top.sv
tb_beam_timing.sv
